// ==== verilog.f ====
+incdir+src
src/alu_pkg.sv
src/alu_slice.sv
src/carry_lookahead.sv
src/alu_func_decode.sv
src/alu_core.sv
src/alu_stage.sv
bench/tb_alu_stage.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the ALU stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timescale 1ns/1ps \
   -f verilog.f --top-module tb_alu_stage -o sim_alu_stage

./obj_dir/sim_alu_stage | tee sim.log

if grep -q "^NO ERRORS$" sim.log; then
   echo "run.sh: simulation passed"
else
   echo "run.sh: simulation failed"
   exit 1
fi

// ==== bench/tb_alu_stage.sv ====
`default_nettype none

module tb_alu_stage;

   timeunit 1ns;
   timeprecision 1ps;

   import alu_pkg::*;

   localparam int WAIT_LIMIT = 8;

   logic     clk;
   logic     rst_n;
   logic     in_valid;
   alu_req_t in_req;
   logic     out_valid;
   alu_rsp_t out_rsp;

   // Responses expected from the DUT in arrival order
   alu_rsp_t exp_q[$];

   alu_stage i_alu_stage (
      .clk       (clk),
      .rst_n     (rst_n),
      .in_valid  (in_valid),
      .in_req    (in_req),
      .out_valid (out_valid),
      .out_rsp   (out_rsp)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   //////////////////////////////
   // Reference model
   //////////////////////////////

   function automatic alu_ctl_t decode_model(input alu_req_t r);
      alu_ctl_t c;
      logic     div_last;
      logic     div_add;
      logic     div_sub;
      logic     add;
      logic     sub;
      div_last = r.q[0] | r.ir[6];
      div_add  = r.div & (r.ir[5] | ~div_last);
      div_sub  = r.div & div_last;
      add = (div_add & ~r.a[31]) | (div_sub & r.a[31]) | r.mul;
      sub = (r.mul & ~r.q[0]) | (div_sub & ~r.a[31]) | (div_add & r.a[31]) | r.irjump;
      if (add && sub) begin
         c.func = 4'b1111;
         c.mode = 1'b1;
         c.cin0 = 1'b1;
      end else if (add) begin
         c.func = 4'b1001;
         c.mode = 1'b0;
         c.cin0 = 1'b0;
      end else if (sub) begin
         c.func = 4'b0110;
         c.mode = 1'b0;
         c.cin0 = ~r.irjump;
      end else begin
         c.func = {r.ir[3], r.ir[4], ~r.ir[6], ~r.ir[5]};
         c.mode = ~r.ir[7];
         c.cin0 = r.ir[2];
      end
      c.osel = r.iralu ? r.ir[13:12] : 2'b00;
      return c;
   endfunction

   // 74181 table returning {carry, result}
   function automatic logic [32:0] alu_function(input word_t a, input word_t b,
                                                input alu_ctl_t c);
      word_t       lg;
      logic [63:0] xy;
      logic [32:0] sum;
      case (c.func)
         4'h0: lg = ~a;
         4'h1: lg = ~(a | b);
         4'h2: lg = ~a & b;
         4'h3: lg = '0;
         4'h4: lg = ~(a & b);
         4'h5: lg = ~b;
         4'h6: lg = a ^ b;
         4'h7: lg = a & ~b;
         4'h8: lg = ~a | b;
         4'h9: lg = ~(a ^ b);
         4'ha: lg = b;
         4'hb: lg = a & b;
         4'hc: lg = '1;
         4'hd: lg = a | ~b;
         4'he: lg = a | b;
         4'hf: lg = a;
      endcase
      // Each arithmetic function as two addends where minus 1 is all ones
      case (c.func)
         4'h0: xy = {a, 32'h0};
         4'h1: xy = {a | b, 32'h0};
         4'h2: xy = {a | ~b, 32'h0};
         4'h3: xy = {32'hffff_ffff, 32'h0};
         4'h4: xy = {a, a & ~b};
         4'h5: xy = {a | b, a & ~b};
         4'h6: xy = {a, ~b};
         4'h7: xy = {a & ~b, 32'hffff_ffff};
         4'h8: xy = {a, a & b};
         4'h9: xy = {a, b};
         4'ha: xy = {a | ~b, a & b};
         4'hb: xy = {a & b, 32'hffff_ffff};
         4'hc: xy = {a, a};
         4'hd: xy = {a | b, a};
         4'he: xy = {a | ~b, a};
         4'hf: xy = {a, 32'hffff_ffff};
      endcase
      sum = {1'b0, xy[63:32]} + {1'b0, xy[31:0]} + {32'h0, c.cin0};
      // Carry pin follows the adder in both modes
      return {sum[32], c.mode ? lg : sum[31:0]};
   endfunction

   function automatic alu_rsp_t expected_rsp(input alu_req_t r);
      alu_ctl_t    c;
      logic [32:0] res;
      alu_rsp_t    e;
      c = decode_model(r);
      res = alu_function(r.a, r.m, c);
      e.alu       = res[31:0];
      e.carry_out = res[32];
      case (c.osel)
         2'd0: e.obus = e.alu;
         2'd1: e.obus = {e.carry_out, e.alu[31:1]};
         2'd2: e.obus = {e.alu[30:0], r.q[31]};
         default: e.obus = r.q;
      endcase
      return e;
   endfunction

   //////////////////////////////
   // Checks
   //////////////////////////////

   task automatic fail_run(input string why);
      $display("%s", why);
      $display("ERRORS FOUND");
      $fatal(1, "stopped at first error");
   endtask

   task automatic compare(input string name, input word_t got, input word_t exp);
      if (got !== exp) begin
         fail_run($sformatf("MISMATCH at %0t: %s got 0x%h expected 0x%h",
                            $time, name, got, exp));
      end
   endtask

   task automatic check_rsp();
      alu_rsp_t e;
      e = exp_q.pop_front();
      compare("obus", out_rsp.obus, e.obus);
      compare("alu", out_rsp.alu, e.alu);
      compare("carry_out", 32'(out_rsp.carry_out), 32'(e.carry_out));
   endtask

   //////////////////////////////
   // Stimulus
   //////////////////////////////

   function automatic logic rand_bit();
      logic [31:0] r;
      r = $urandom;
      return r[0];
   endfunction

   // Three strobes in four cycles on average
   function automatic logic rand_valid();
      logic [31:0] r;
      r = $urandom;
      return r[1:0] != 2'b00;
   endfunction

   function automatic alu_req_t rand_req(input logic mul, input logic div,
                                         input logic irjump);
      alu_req_t    r;
      logic [63:0] ir_bits;
      ir_bits  = {$urandom, $urandom};
      r.a      = $urandom;
      r.m      = $urandom;
      r.q      = $urandom;
      r.ir     = ir_bits[48:0];
      r.iralu  = rand_bit();
      r.irjump = irjump;
      r.div    = div;
      r.mul    = mul;
      return r;
   endfunction

   // Plain op with the ir fields set for a wanted function
   function automatic alu_req_t plain_req(input alu_func_t func, input logic mode,
                                          input logic cin);
      alu_req_t r;
      r = rand_req(1'b0, 1'b0, 1'b0);
      r.ir[3] = func[3];
      r.ir[4] = func[2];
      r.ir[6] = ~func[1];
      r.ir[5] = ~func[0];
      r.ir[7] = ~mode;
      r.ir[2] = cin;
      return r;
   endfunction

   // Drives one cycle and checks the result due from a strobe
   task automatic step(input logic valid, input alu_req_t req);
      in_valid = valid;
      in_req   = req;
      if (valid) begin
         exp_q.push_back(expected_rsp(req));
      end
      @(negedge clk);
      compare("out_valid", 32'(out_valid), 32'(valid));
      if (valid) begin
         check_rsp();
      end
   endtask

   task automatic single_strobe(input alu_req_t req);
      int cycles;
      in_valid = 1'b1;
      in_req   = req;
      exp_q.push_back(expected_rsp(req));
      @(negedge clk);
      in_valid = 1'b0;
      cycles = 1;
      while (out_valid !== 1'b1) begin
         if (cycles >= WAIT_LIMIT) begin
            fail_run("Timed out waiting for out_valid after a strobe");
         end else begin
            @(negedge clk);
            cycles++;
         end
      end
      compare("latency", 32'(cycles), 32'd1);
      check_rsp();
   endtask

   //////////////////////////////
   // Main sequence
   //////////////////////////////

   initial begin
      alu_req_t req;
      void'($urandom(89));
      rst_n    = 1'b0;
      in_valid = 1'b0;
      in_req   = '0;
      repeat (3) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;

      // out_valid stays low until the first strobe
      repeat (4) step(1'b0, rand_req(1'b0, 1'b0, 1'b0));
      single_strobe(plain_req(4'b1001, 1'b0, 1'b1));

      // All logic and arithmetic functions with strobes back to back
      for (int md = 0; md < 2; md++) begin
         for (int fn = 0; fn < 16; fn++) begin
            repeat (6) step(1'b1, plain_req(4'(fn), 1'(md), rand_bit()));
            // Carry ripples across both lookahead levels
            req = plain_req(4'(fn), 1'(md), 1'b1);
            req.m = ~req.a;
            step(1'b1, req);
            req = plain_req(4'(fn), 1'(md), 1'b0);
            req.a = 32'hffff_ffff;
            req.m = 32'h0000_0001;
            step(1'b1, req);
         end
      end

      repeat (300) step(rand_valid(), rand_req(1'b0, 1'b0, 1'b0));
      // Multiply steps
      repeat (100) step(rand_valid(), rand_req(1'b1, 1'b0, 1'b0));
      // Divide steps
      repeat (150) step(rand_valid(), rand_req(1'b0, 1'b1, 1'b0));
      // Jumps
      repeat (100) step(rand_valid(), rand_req(1'b0, 1'b0, 1'b1));

      // Each output select with iralu high and then with iralu low
      for (int s = 0; s < 4; s++) begin
         repeat (20) begin
            req = rand_req(1'b0, 1'b0, 1'b0);
            req.iralu = 1'b1;
            req.ir[13:12] = 2'(s);
            step(1'b1, req);
         end
      end
      repeat (20) begin
         req = rand_req(1'b0, 1'b0, 1'b0);
         req.iralu = 1'b0;
         req.ir[13:12] = 2'b11;
         step(1'b1, req);
      end

      single_strobe(rand_req(1'b0, 1'b1, 1'b0));
      step(1'b0, rand_req(1'b0, 1'b0, 1'b0));

      $display("NO ERRORS");
      $finish;
   end

endmodule

`default_nettype wire

// ==== src/alu_stage.sv ====
`default_nettype none

// ALU stage with function decode, output bus select and result register
module alu_stage (
   input  logic              clk,
   input  logic              rst_n,
   input  logic              in_valid,
   input  alu_pkg::alu_req_t in_req,
   output logic              out_valid,
   output alu_pkg::alu_rsp_t out_rsp
);

   import alu_pkg::*;

   alu_ctl_t ctl;
   word_t    alu;
   logic     carry_out;
   word_t    obus;
   alu_rsp_t rsp_next;

   //////////////////////////////
   // Decode and ALU
   //////////////////////////////

   alu_func_decode i_alu_func_decode (
      .req (in_req),
      .ctl (ctl)
   );

   alu_core i_alu_core (
      .a         (in_req.a),
      .m         (in_req.m),
      .ctl       (ctl),
      .alu       (alu),
      .carry_out (carry_out)
   );

   //////////////////////////////
   // Output bus select
   //////////////////////////////

   always_comb begin
      case (ctl.osel)
         2'd1: begin
            // Carry enters at the top on a right shift
            obus = {carry_out, alu[31:1]};
         end
         2'd2: begin
            // Q msb enters at the bottom on a left shift
            obus = {alu[30:0], in_req.q[31]};
         end
         2'd3: begin
            obus = in_req.q;
         end
         default: begin
            obus = alu;
         end
      endcase
   end

   always_comb begin
      rsp_next.obus      = obus;
      rsp_next.alu       = alu;
      rsp_next.carry_out = carry_out;
   end

   //////////////////////////////
   // Result register
   //////////////////////////////

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         out_valid <= 1'b0;
         out_rsp   <= '0;
      end else begin
         out_valid <= in_valid;
         if (in_valid) begin
            out_rsp <= rsp_next;
         end
      end
   end

   // The slice and lookahead network must add like a plain adder
   assert property (@(posedge clk) disable iff (!rst_n)
                    (in_valid && ctl.func == 4'b1001 && !ctl.mode)
                    |-> {carry_out, alu} == 33'(in_req.a) + 33'(in_req.m) + 33'(ctl.cin0))
      else $error("alu_stage: A plus M disagrees with a plain adder");

endmodule

`default_nettype wire

// ==== src/alu_core.sv ====
`default_nettype none

`include "alu_cfg.svh"

// 32-bit ALU from eight slices and two levels of lookahead
module alu_core (
   input  alu_pkg::word_t    a,
   input  alu_pkg::word_t    m,
   input  alu_pkg::alu_ctl_t ctl,
   output alu_pkg::word_t    alu,
   output logic              carry_out
);

   import alu_pkg::*;

   localparam int NSLICE = `ALU_WIDTH / 4;

   // Per-slice carry in and group terms, all active low
   logic [NSLICE-1:0] slice_cin_n;
   logic [NSLICE-1:0] gx;
   logic [NSLICE-1:0] gy;

   logic [2:0] lo_cout_n;
   logic [2:0] hi_cout_n;
   logic [2:0] top_cout_n;
   logic       lo_x, lo_y;
   logic       hi_x, hi_y;

   //////////////////////////////
   // Slices
   //////////////////////////////

   for (genvar k = 0; k < NSLICE; k++) begin : g_slice
      alu_slice i_slice (
         .a     (a[4*k +: 4]),
         .b     (m[4*k +: 4]),
         .func  (ctl.func),
         .mode  (ctl.mode),
         .cin_n (slice_cin_n[k]),
         .f     (alu[4*k +: 4]),
         .x     (gx[k]),
         .y     (gy[k])
      );
   end

   assign slice_cin_n = {hi_cout_n, top_cout_n[0], lo_cout_n, ~ctl.cin0};

   //////////////////////////////
   // Lookahead
   //////////////////////////////

   // Low half, bits 0 to 15
   carry_lookahead i_cla_lo (
      .x      (gx[3:0]),
      .y      (gy[3:0]),
      .cin_n  (~ctl.cin0),
      .cout_n (lo_cout_n),
      .xout   (lo_x),
      .yout   (lo_y)
   );

   // High half, carry in from the second level
   carry_lookahead i_cla_hi (
      .x      (gx[7:4]),
      .y      (gy[7:4]),
      .cin_n  (top_cout_n[0]),
      .cout_n (hi_cout_n),
      .xout   (hi_x),
      .yout   (hi_y)
   );

   // Second level, only two groups in use
   carry_lookahead i_cla_top (
      .x      ({2'b00, hi_x, lo_x}),
      .y      ({2'b00, hi_y, lo_y}),
      .cin_n  (~ctl.cin0),
      .cout_n (top_cout_n),
      .xout   (),
      .yout   ()
   );

   assign carry_out = ~top_cout_n[1];

endmodule

`default_nettype wire

// ==== src/alu_func_decode.sv ====
`default_nettype none

`include "alu_cfg.svh"

// ALU function, mode, carry in and output select
module alu_func_decode (
   input  alu_pkg::alu_req_t req,
   output alu_pkg::alu_ctl_t ctl
);

   import alu_pkg::*;

   logic    div_last;
   logic    div_add;
   logic    div_sub;
   logic    mul_nop;
   logic    add;
   logic    sub;
   alu_op_e op;

   //////////////////////////////
   // Step conditions
   //////////////////////////////

   // Sign of the partial remainder picks add or subtract on a divide step
   assign div_last = req.q[0] | req.ir[`IR_DIVFIRST_BIT];
   assign div_add  = req.div & (req.ir[`IR_DIVREM_BIT] | ~div_last);
   assign div_sub  = req.div & div_last;

   // Multiply step with a zero multiplier bit passes A through
   assign mul_nop = req.mul & ~req.q[0];

   assign add = (div_add & ~req.a[31]) | (div_sub & req.a[31]) | req.mul;
   assign sub = mul_nop | (div_sub & ~req.a[31]) | (div_add & req.a[31]) | req.irjump;

   assign op = alu_op_e'({sub, add});

   //////////////////////////////
   // Control fields
   //////////////////////////////

   always_comb begin
      case (op)
         op_add: begin
            ctl.func = 4'b1001;
            ctl.mode = 1'b0;
            ctl.cin0 = 1'b0;
         end
         op_sub: begin
            // Jumps compare with A - M - 1
            ctl.func = 4'b0110;
            ctl.mode = 1'b0;
            ctl.cin0 = ~req.irjump;
         end
         op_pass: begin
            ctl.func = 4'b1111;
            ctl.mode = 1'b1;
            ctl.cin0 = 1'b1;
         end
         default: begin
            // Function field bits come in a scrambled order
            ctl.func = {req.ir[`IR_FUNC_LO], req.ir[`IR_FUNC_LO+1],
                        ~req.ir[`IR_FUNC_HI], ~req.ir[`IR_FUNC_HI-1]};
            ctl.mode = ~req.ir[`IR_MODE_BIT];
            ctl.cin0 = req.ir[`IR_CIN_BIT];
         end
      endcase
   end

   assign ctl.osel = req.iralu ? req.ir[`IR_OSEL_LO +: 2] : 2'b00;

   // A divide step passes A through only with the remainder qualifier set
   always_comb begin
      if (req.div && !req.mul && !req.irjump && op == op_pass) begin
         assert (req.ir[`IR_DIVREM_BIT])
            else $error("alu_func_decode: divide step passed A without ir[5]");
      end
   end

endmodule

`default_nettype wire

// ==== src/carry_lookahead.sv ====
`default_nettype none

// Four-group lookahead on the 74182 equations with all pins active low
module carry_lookahead (
   input  logic [3:0] x,
   input  logic [3:0] y,
   input  logic       cin_n,
   output logic [2:0] cout_n,
   output logic       xout,
   output logic       yout
);

   // Active-high group propagate, generate and carry in
   logic [3:0] p;
   logic [3:0] g;
   logic       c;

   // Carries into groups 1 to 3 rippled group by group
   logic [2:0] ripple;

   assign p = ~x;
   assign g = ~y;
   assign c = ~cin_n;

   //////////////////////////////
   // Carries into groups 1 to 3
   //////////////////////////////

   assign cout_n[0] = ~(g[0] | (p[0] & c));

   assign cout_n[1] = ~(g[1]
                        | (p[1] & g[0])
                        | (p[1] & p[0] & c));

   assign cout_n[2] = ~(g[2]
                        | (p[2] & g[1])
                        | (p[2] & p[1] & g[0])
                        | (p[2] & p[1] & p[0] & c));

   //////////////////////////////
   // Block propagate and generate
   //////////////////////////////

   assign xout = ~(p[3] & p[2] & p[1] & p[0]);

   assign yout = ~(g[3]
                   | (p[3] & g[2])
                   | (p[3] & p[2] & g[1])
                   | (p[3] & p[2] & p[1] & g[0]));

   assign ripple[0] = g[0] | (p[0] & c);
   assign ripple[1] = g[1] | (p[1] & ripple[0]);
   assign ripple[2] = g[2] | (p[2] & ripple[1]);

   // Expanded lookahead terms must agree with the rippled carries
   always_comb begin
      if (!$isunknown({x, y, cin_n})) begin
         assert (cout_n == ~ripple)
            else $error("carry_lookahead: carries disagree with a group ripple");
      end
   end

endmodule

`default_nettype wire

// ==== src/alu_slice.sv ====
`default_nettype none

// 4-bit slice with the 74181 function table, active-high data
module alu_slice (
   input  alu_pkg::nibble_t   a,
   input  alu_pkg::nibble_t   b,
   input  alu_pkg::alu_func_t func,
   input  logic               mode,
   input  logic               cin_n,
   output alu_pkg::nibble_t   f,
   output logic               x,
   output logic               y
);

   import alu_pkg::*;

   //////////////////////////////
   // Per-bit operand terms
   //////////////////////////////

   // The table reduces to t1 + t2 + carry, and t2 is always a subset of t1
   nibble_t t1;
   nibble_t t2;

   // Carry into each bit, active high
   nibble_t cy;

   always_comb begin
      t1 = a | (b & {4{func[0]}}) | (~b & {4{func[1]}});
      t2 = (a & b & {4{func[3]}}) | (a & ~b & {4{func[2]}});
   end

   //////////////////////////////
   // Internal ripple carry
   //////////////////////////////

   // Bit carry generate is t2, propagate is t1
   always_comb begin
      cy[0] = ~cin_n;
      cy[1] = t2[0] | (t1[0] & cy[0]);
      cy[2] = t2[1] | (t1[1] & cy[1]);
      cy[3] = t2[2] | (t1[2] & cy[2]);
   end

   //////////////////////////////
   // Function output
   //////////////////////////////

   always_comb begin
      if (mode) begin
         // Logic functions, carries have no effect
         f = ~(t1 ^ t2);
      end else begin
         f = t1 ^ t2 ^ cy;
      end
   end

   //////////////////////////////
   // Group terms for the 74182
   //////////////////////////////

   // Propagate, active low
   assign x = ~(t1[3] & t1[2] & t1[1] & t1[0]);

   // Generate, active low
   assign y = ~(t2[3]
                | (t1[3] & t2[2])
                | (t1[3] & t1[2] & t2[1])
                | (t1[3] & t1[2] & t1[1] & t2[0]));

endmodule

`default_nettype wire

// ==== src/alu_pkg.sv ====
`default_nettype none

`include "alu_cfg.svh"

package alu_pkg;

   //////////////////////////////
   // Vector types
   //////////////////////////////

   typedef logic [`ALU_WIDTH-1:0] word_t;
   typedef logic [`IR_WIDTH-1:0] ir_word_t;
   typedef logic [3:0] alu_func_t;
   typedef logic [3:0] nibble_t;
   typedef logic [1:0] osel_t;

   // Encoded as {sub, add}
   typedef enum logic [1:0] {
      op_ir   = 2'b00,
      op_add  = 2'b01,
      op_sub  = 2'b10,
      op_pass = 2'b11
   } alu_op_e;

   //////////////////////////////
   // Bundles
   //////////////////////////////

   typedef struct packed {
      word_t    a;
      word_t    m;
      word_t    q;
      ir_word_t ir;
      logic     iralu;
      logic     irjump;
      logic     div;
      logic     mul;
   } alu_req_t;

   typedef struct packed {
      alu_func_t func;
      logic      mode;
      logic      cin0;
      osel_t     osel;
   } alu_ctl_t;

   typedef struct packed {
      word_t obus;
      word_t alu;
      logic  carry_out;
   } alu_rsp_t;

endpackage

`default_nettype wire

// ==== src/alu_cfg.svh ====
`ifndef ALU_CFG_SVH
`define ALU_CFG_SVH

// Datapath and instruction register widths
`define ALU_WIDTH 32
`define IR_WIDTH 49

// Carry, function and mode fields of ir
`define IR_CIN_BIT 2
`define IR_FUNC_LO 3
`define IR_FUNC_HI 6
`define IR_MODE_BIT 7

// Divide step qualifiers, sharing bits with the function field
`define IR_DIVFIRST_BIT 6
`define IR_DIVREM_BIT 5

// Two-bit output select, low bit position
`define IR_OSEL_LO 12

`endif
